// File: trig_sample_fifo_testdata.txt
# case line: samp_max event_count base_g1 .. base_g6 (bases in hex)
# event line: strobe_index kind (1 l1a alone, 2 l1a with match)
3 1 100 200 300 400 500 600
0 2
# l1a alone around a match
2 4 010 020 030 040 050 060
0 1
1 1
3 2
7 1
# one overlap during capture
4 2 a00 b00 c00 d00 e00 f00
0 2
2 2
# short events back to back
0 3 001 002 003 004 005 006
0 2
1 2
5 2
# overlaps stacked
2 3 7f0 6f0 5f0 4f0 3f0 2f0
0 2
1 2
2 2
# long event
12 1 0ab 1ab 2ab 3ab 4ab 5ab
2 2

// File: trig_sample_fifo.f
daq_pkg.sv
load_ctrl_if.sv
fifo_load_fsm.sv
load_counter.sv
chan_fifo_bank.sv
l1a_info_fifo.sv
trig_sample_fifo.sv
trig_sample_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log
rm -f sim.log

verilator --binary -j 0 --top-module trig_sample_fifo_tb -f trig_sample_fifo.f \
	-o trig_sample_fifo_sim > sim.log 2>&1 &&
	./obj_dir/trig_sample_fifo_sim >> sim.log 2>&1 ||
	echo "Finished with errors (build or run stopped)" >> sim.log

grep -q "Finished with errors" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; } ||
	{ echo "simulation passed"; exit 0; }

// File: trig_sample_fifo_tb.sv
`timescale 1ns/100ps

module trig_sample_fifo_tb;
	import daq_pkg::*;

	localparam int BUS_W = NUM_CH * SMP_W;

	logic                  CLK40;
	logic                  RST_RESYNC;
	logic                  l1a;
	logic                  l1a_match;
	logic                  smp_stb;
	logic [SMAX_W-1:0]     samp_max;
	logic [BUS_W-1:0]      grp [NUM_GRP];  // g1_in .. g6_in
	logic [NUM_CH-1:0]     rd_en;
	logic                  info_rd_en;
	logic                  rdy;
	logic [BUS_W-1:0]      dout_16ch;
	logic [NUM_CH-1:0]     fifo_empty;
	logic [INFO_W-1:0]     info_out;
	logic [L1A_CNT_W-1:0]  l1a_cnt;
	logic [MTCH_CNT_W-1:0] l1a_mtch_cnt;

	////////////////////////////////////////////////////////////
	// reference model state
	////////////////////////////////////////////////////////////
	logic [BUS_W-1:0]  exp_q [$];   // one bus word per group write
	logic [INFO_W-1:0] info_q [$];
	logic [SMP_W-1:0]  base [NUM_GRP];
	int ev_idx [$];
	int ev_kind [$];
	int n_l1a;
	int n_mtch;
	int ovl;
	int remaining;   // sample periods still to capture
	int smp_idx;
	int n_err;
	int fd;
	int cyc;
	int limit = 200;

	trig_sample_fifo uut (
		.CLK40        (CLK40),
		.RST_RESYNC   (RST_RESYNC),
		.l1a          (l1a),
		.l1a_match    (l1a_match),
		.smp_stb      (smp_stb),
		.samp_max     (samp_max),
		.g1_in        (grp[0]),
		.g2_in        (grp[1]),
		.g3_in        (grp[2]),
		.g4_in        (grp[3]),
		.g5_in        (grp[4]),
		.g6_in        (grp[5]),
		.rd_en        (rd_en),
		.info_rd_en   (info_rd_en),
		.rdy          (rdy),
		.dout_16ch    (dout_16ch),
		.fifo_empty   (fifo_empty),
		.info_out     (info_out),
		.l1a_cnt      (l1a_cnt),
		.l1a_mtch_cnt (l1a_mtch_cnt)
	);

	initial begin
		CLK40 = 1'b0;
		forever #50 CLK40 = ~CLK40;
	end

	initial begin
		cyc = 0;
		while (cyc <= limit) begin
			@(posedge CLK40);
			cyc++;
		end
		$display("timeout after %0d cycles, the test sequence did not complete", cyc);
		$display("Finished with errors");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [BUS_W-1:0] got,
			input logic [BUS_W-1:0] exp);
		n_err++;
		$display("Error: %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
	endtask

	// next line of testdata that is not a comment
	task automatic next_line(output string s, output bit got);
		int r;
		got = 1'b0;
		s = "";
		while (!got && !$feof(fd)) begin
			r = $fgets(s, fd);
			if (r > 0 && s.len() > 1 && s.getc(0) != "#")
				got = 1'b1;
		end
	endtask

	// one 8-cycle sample period, strobe on the first falling edge
	task automatic sample_period(input int kind, input int smax);
		logic ovl_flag;
		ovl_flag = 1'b0;
		for (int g = 0; g < NUM_GRP; g++) begin
			for (int w = 0; w < BUS_W / 32; w++)
				grp[g][w*32 +: 32] = $urandom;
			grp[g][SMP_W-1:0] = base[g] + SMP_W'(smp_idx);  // channel 0 tags the period
		end
		smp_idx++;
		smp_stb   = 1'b1;
		l1a       = (kind != 0);
		l1a_match = (kind == 2);
		if (kind != 0)
			n_l1a++;
		if (kind == 2) begin
			n_mtch++;
			if (remaining == 0) begin
				remaining = smax + 1;
			end else begin
				ovl_flag = 1'b1;  // match while capturing
				if (ovl < (1 << OVL_W) - 1)
					ovl++;
			end
			info_q.push_back({ovl_flag, OVL_W'(ovl), MTCH_CNT_W'(n_mtch), L1A_CNT_W'(n_l1a)});
		end
		if (remaining > 0) begin
			for (int g = 0; g < NUM_GRP; g++)
				exp_q.push_back(grp[g]);
			remaining--;
			if (remaining == 0 && ovl > 0) begin  // one more full event
				ovl--;
				remaining = smax + 1;
			end
		end
		@(negedge CLK40);
		smp_stb   = 1'b0;
		l1a       = 1'b0;
		l1a_match = 1'b0;
		repeat (7) @(negedge CLK40);
	endtask

	////////////////////////////////////////////////////////////
	// readout and compare
	////////////////////////////////////////////////////////////
	task automatic drain_and_check();
		logic [BUS_W-1:0]  exp_w;
		logic [INFO_W-1:0] exp_i;
		logic [BUS_W-1:0]  held;
		logic [INFO_W-1:0] held_i;
		if (l1a_cnt !== L1A_CNT_W'(n_l1a))
			report_mismatch("l1a_cnt", BUS_W'(l1a_cnt), BUS_W'(n_l1a));
		if (l1a_mtch_cnt !== MTCH_CNT_W'(n_mtch))
			report_mismatch("l1a_mtch_cnt", BUS_W'(l1a_mtch_cnt), BUS_W'(n_mtch));
		while (info_q.size() > 0) begin
			exp_i = info_q.pop_front();
			if (rdy !== 1'b1)
				report_mismatch("rdy", BUS_W'(rdy), BUS_W'(1'b1));
			if (info_out !== exp_i)
				report_mismatch("info_out", BUS_W'(info_out), BUS_W'(exp_i));
			info_rd_en = 1'b1;
			@(negedge CLK40);
			info_rd_en = 1'b0;
		end
		if (rdy !== 1'b0)
			report_mismatch("rdy", BUS_W'(rdy), BUS_W'(1'b0));
		held_i     = info_out;
		info_rd_en = 1'b1;  // one extra read on the empty info fifo
		@(negedge CLK40);
		info_rd_en = 1'b0;
		if (rdy !== 1'b0)
			report_mismatch("rdy", BUS_W'(rdy), BUS_W'(1'b0));
		if (info_out !== held_i)
			report_mismatch("info_out", BUS_W'(info_out), BUS_W'(held_i));
		while (exp_q.size() > 0) begin
			exp_w = exp_q.pop_front();
			if (fifo_empty !== '0)
				report_mismatch("fifo_empty", BUS_W'(fifo_empty), '0);
			if (dout_16ch !== exp_w)
				report_mismatch("dout_16ch", dout_16ch, exp_w);
			rd_en = '1;
			@(negedge CLK40);
			rd_en = '0;
		end
		if (fifo_empty !== '1)
			report_mismatch("fifo_empty", BUS_W'(fifo_empty), BUS_W'({NUM_CH{1'b1}}));
		held  = dout_16ch;
		rd_en = '1;
		@(negedge CLK40);
		rd_en = '0;
		if (fifo_empty !== '1)
			report_mismatch("fifo_empty", BUS_W'(fifo_empty), BUS_W'({NUM_CH{1'b1}}));
		if (dout_16ch !== held)
			report_mismatch("dout_16ch", dout_16ch, held);
	endtask

	task automatic run_case(input int smax);
		int k;
		int e;
		k = 0;
		e = 0;
		samp_max = SMAX_W'(smax);
		while (e < ev_idx.size() || remaining > 0) begin
			if (e < ev_idx.size() && ev_idx[e] == k) begin
				sample_period(ev_kind[e], smax);
				e++;
			end else begin
				sample_period(0, smax);
			end
			k++;
		end
		drain_and_check();
	endtask

	initial begin
		string line;
		bit    got;
		int    r;
		int    smax;
		int    nev;
		int    ei;
		int    ek;
		int    n_case;
		void'($urandom(32'h72ad071e));
		n_err     = 0;
		n_case    = 0;
		n_l1a     = 0;
		n_mtch    = 0;
		ovl       = 0;
		remaining = 0;
		smp_idx   = 0;
		RST_RESYNC = 1'b1;
		l1a        = 1'b0;
		l1a_match  = 1'b0;
		smp_stb    = 1'b0;
		samp_max   = '0;
		rd_en      = '0;
		info_rd_en = 1'b0;
		for (int g = 0; g < NUM_GRP; g++)
			grp[g] = '0;
		repeat (5) @(negedge CLK40);
		RST_RESYNC = 1'b0;

		// idle after reset
		if (rdy !== 1'b0)
			report_mismatch("rdy", BUS_W'(rdy), BUS_W'(1'b0));
		if (fifo_empty !== '1)
			report_mismatch("fifo_empty", BUS_W'(fifo_empty), BUS_W'({NUM_CH{1'b1}}));
		if (l1a_cnt !== '0)
			report_mismatch("l1a_cnt", BUS_W'(l1a_cnt), '0);
		if (l1a_mtch_cnt !== '0)
			report_mismatch("l1a_mtch_cnt", BUS_W'(l1a_mtch_cnt), '0);

		fd = $fopen("trig_sample_fifo_testdata.txt", "r");
		if (fd == 0) begin
			n_err++;
			$display("testdata file could not be opened");
		end else begin
			next_line(line, got);
			while (got) begin
				r = $sscanf(line, "%d %d %h %h %h %h %h %h", smax, nev,
					base[0], base[1], base[2], base[3], base[4], base[5]);
				ev_idx.delete();
				ev_kind.delete();
				for (int i = 0; i < nev; i++) begin
					next_line(line, got);
					r += $sscanf(line, "%d %d", ei, ek);
					ev_idx.push_back(ei);
					ev_kind.push_back(ek);
				end
				if (r != 8 + 2 * nev) begin
					n_err++;
					$display("testdata case %0d is malformed", n_case);
				end
				limit += 2 * (smax + 2) * 8 * (nev + 1) + 8 * (ei + 1);
				run_case(smax);
				n_case++;
				next_line(line, got);
			end
			$fclose(fd);
		end

		$display("%0d cases run, %0d errors counted", n_case, n_err);
		if (n_err == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: trig_sample_fifo.sv
`timescale 1ns/100ps

module trig_sample_fifo (
	input  logic                                      CLK40,
	input  logic                                      RST_RESYNC,
	input  logic                                      l1a,
	input  logic                                      l1a_match,
	input  logic                                      smp_stb,
	input  logic [daq_pkg::SMAX_W-1:0]                  samp_max,
	input  logic [daq_pkg::NUM_CH*daq_pkg::SMP_W-1:0]  g1_in,
	input  logic [daq_pkg::NUM_CH*daq_pkg::SMP_W-1:0]  g2_in,
	input  logic [daq_pkg::NUM_CH*daq_pkg::SMP_W-1:0]  g3_in,
	input  logic [daq_pkg::NUM_CH*daq_pkg::SMP_W-1:0]  g4_in,
	input  logic [daq_pkg::NUM_CH*daq_pkg::SMP_W-1:0]  g5_in,
	input  logic [daq_pkg::NUM_CH*daq_pkg::SMP_W-1:0]  g6_in,
	input  logic [daq_pkg::NUM_CH-1:0]                  rd_en,
	input  logic                                      info_rd_en,
	output logic                                      rdy,
	output logic [daq_pkg::NUM_CH*daq_pkg::SMP_W-1:0]  dout_16ch,
	output logic [daq_pkg::NUM_CH-1:0]                  fifo_empty,
	output logic [daq_pkg::INFO_W-1:0]                  info_out,
	output logic [daq_pkg::L1A_CNT_W-1:0]               l1a_cnt,
	output logic [daq_pkg::MTCH_CNT_W-1:0]              l1a_mtch_cnt
);
	import daq_pkg::*;

	logic             busy;
	logic             evt_done;
	logic             ovl_pend;
	logic [OVL_W-1:0] ovl_cnt;

	load_ctrl_if lc ();

	fifo_load_fsm u_fsm (
		.CLK40      (CLK40),
		.RST_RESYNC (RST_RESYNC),
		.l1a_match  (l1a_match),
		.smp_stb    (smp_stb),
		.ovl_pend   (ovl_pend),
		.lc         (lc.fsm),
		.busy       (busy),
		.evt_done   (evt_done)
	);

	load_counter u_cnt (
		.CLK40      (CLK40),
		.RST_RESYNC (RST_RESYNC),
		.samp_max   (samp_max),
		.l1a_match  (l1a_match),
		.busy       (busy),
		.evt_done   (evt_done),
		.lc         (lc.cnt),
		.ovl_cnt    (ovl_cnt),
		.ovl_pend   (ovl_pend)
	);

	// g1 lands at index 0
	chan_fifo_bank u_bank (
		.CLK40      (CLK40),
		.RST_RESYNC (RST_RESYNC),
		.g_in       ({g6_in, g5_in, g4_in, g3_in, g2_in, g1_in}),
		.lc         (lc.bank),
		.rd_en      (rd_en),
		.dout_16ch  (dout_16ch),
		.fifo_empty (fifo_empty)
	);

	l1a_info_fifo u_info (
		.CLK40        (CLK40),
		.RST_RESYNC   (RST_RESYNC),
		.l1a          (l1a),
		.l1a_match    (l1a_match),
		.busy         (busy),
		.ovl_cnt      (ovl_cnt),
		.info_rd_en   (info_rd_en),
		.l1a_cnt      (l1a_cnt),
		.l1a_mtch_cnt (l1a_mtch_cnt),
		.info_out     (info_out),
		.rdy          (rdy)
	);

endmodule

// File: l1a_info_fifo.sv
`timescale 1ns/100ps

module l1a_info_fifo (
	input  logic                          CLK40,
	input  logic                          RST_RESYNC,
	input  logic                          l1a,
	input  logic                          l1a_match,
	input  logic                          busy,
	input  logic [daq_pkg::OVL_W-1:0]      ovl_cnt,
	input  logic                          info_rd_en,
	output logic [daq_pkg::L1A_CNT_W-1:0]  l1a_cnt,
	output logic [daq_pkg::MTCH_CNT_W-1:0] l1a_mtch_cnt,
	output daq_pkg::info_word_t           info_out,
	output logic                          rdy
);
	import daq_pkg::*;

	info_word_t       mem [INFO_DEPTH];
	info_word_t       info_nxt;
	logic [INFO_AW:0] wr_ptr;
	logic [INFO_AW:0] rd_ptr;
	logic             info_empty;
	logic             info_full;

	////////////////////////////////////////////////////////////
	// event counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK40) begin
		if (RST_RESYNC)
			l1a_cnt <= '0;
		else if (l1a)
			l1a_cnt <= l1a_cnt + 1'b1;
	end

	always_ff @(posedge CLK40) begin
		if (RST_RESYNC)
			l1a_mtch_cnt <= '0;
		else if (l1a_match)
			l1a_mtch_cnt <= l1a_mtch_cnt + 1'b1;
	end

	// word carries the counts as they will be after this cycle
	always_comb begin
		info_nxt.ovl_flag = busy;
		if (!busy)
			info_nxt.ovl_cnt = ovl_cnt;
		else if (ovl_cnt == OVL_MAX)
			info_nxt.ovl_cnt = OVL_MAX;  // saturated
		else
			info_nxt.ovl_cnt = ovl_cnt + 1'b1;
		info_nxt.mtch_cnt = l1a_mtch_cnt + 1'b1;
		info_nxt.l1a_cnt  = l1a_cnt + L1A_CNT_W'(l1a);
	end

	////////////////////////////////////////////////////////////
	// info word buffer
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK40) begin
		if (l1a_match && !info_full)
			mem[wr_ptr[INFO_AW-1:0]] <= info_nxt;
	end

	always_ff @(posedge CLK40) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (l1a_match && !info_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (info_rd_en && !info_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign info_empty = (rd_ptr == wr_ptr);
	assign info_full  = (rd_ptr == {~wr_ptr[INFO_AW], wr_ptr[INFO_AW-1:0]});
	assign info_out   = mem[rd_ptr[INFO_AW-1:0]];  // show-ahead
	assign rdy        = ~info_empty;

endmodule

// File: chan_fifo_bank.sv
`timescale 1ns/100ps

module chan_fifo_bank (
	input  logic CLK40,
	input  logic RST_RESYNC,
	input  logic [daq_pkg::NUM_GRP-1:0][daq_pkg::NUM_CH*daq_pkg::SMP_W-1:0] g_in,
	load_ctrl_if.bank lc,
	input  logic [daq_pkg::NUM_CH-1:0] rd_en,
	output logic [daq_pkg::NUM_CH*daq_pkg::SMP_W-1:0] dout_16ch,
	output logic [daq_pkg::NUM_CH-1:0] fifo_empty
);
	import daq_pkg::*;

	logic [NUM_CH*SMP_W-1:0] grp_word;  // selected group bus
	logic [CH_AW:0]          wr_ptr;
	logic [NUM_CH-1:0]       ch_full;
	logic                    wr_ok;

	////////////////////////////////////////////////////////////
	// group multiplexer
	////////////////////////////////////////////////////////////
	always_comb begin
		if (lc.sel < GRP_W'(NUM_GRP))
			grp_word = g_in[lc.sel];
		else
			grp_word = '0;
	end

	// one write pointer for all channels, so a full channel holds the whole bank
	assign wr_ok = lc.wren & ~|ch_full;

	always_ff @(posedge CLK40) begin
		if (RST_RESYNC)
			wr_ptr <= '0;
		else if (wr_ok)
			wr_ptr <= wr_ptr + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// per-channel buffers
	////////////////////////////////////////////////////////////
	for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
		logic [SMP_W-1:0] mem [CH_DEPTH];
		logic [CH_AW:0]   rd_ptr;

		always_ff @(posedge CLK40) begin
			if (wr_ok)
				mem[wr_ptr[CH_AW-1:0]] <= grp_word[c*SMP_W +: SMP_W];
		end

		always_ff @(posedge CLK40) begin
			if (RST_RESYNC)
				rd_ptr <= '0;
			else if (rd_en[c] && !fifo_empty[c])  // empty reads ignored
				rd_ptr <= rd_ptr + 1'b1;
		end

		assign fifo_empty[c] = (rd_ptr == wr_ptr);
		// wrap bit differs, index equal
		assign ch_full[c] = (rd_ptr == {~wr_ptr[CH_AW], wr_ptr[CH_AW-1:0]});

		// show-ahead head word
		assign dout_16ch[c*SMP_W +: SMP_W] = mem[rd_ptr[CH_AW-1:0]];
	end

endmodule

// File: load_counter.sv
`timescale 1ns/100ps

module load_counter (
	input  logic                     CLK40,
	input  logic                     RST_RESYNC,
	input  logic [daq_pkg::SMAX_W-1:0] samp_max,
	input  logic                     l1a_match,
	input  logic                     busy,
	input  logic                     evt_done,
	load_ctrl_if.cnt                 lc,
	output logic [daq_pkg::OVL_W-1:0]  ovl_cnt,
	output logic                     ovl_pend
);
	import daq_pkg::*;

	logic [SMAX_W:0] smp_cnt;  // finished sample periods
	logic            ovl_inc;

	assign lc.grp_last = (lc.sel == GRP_W'(NUM_GRP - 1));
	assign lc.smp_last = (smp_cnt > {1'b0, samp_max});  // samp_max+1 periods done

	assign ovl_inc  = l1a_match & busy;
	assign ovl_pend = (ovl_cnt != '0) | ovl_inc;  // late match in LAST_CHECK too

	always_ff @(posedge CLK40) begin
		if (RST_RESYNC || lc.cnt_clr)
			lc.sel <= '0;
		else if (lc.wren)
			lc.sel <= lc.grp_last ? '0 : lc.sel + 1'b1;
	end

	always_ff @(posedge CLK40) begin
		if (RST_RESYNC || lc.cnt_clr)
			smp_cnt <= '0;
		else if (lc.wren && lc.grp_last)
			smp_cnt <= smp_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// overlap count
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK40) begin
		if (RST_RESYNC) begin
			ovl_cnt <= '0;
		end else begin
			case ({ovl_inc, evt_done})
				2'b10: begin
					if (ovl_cnt != OVL_MAX)
						ovl_cnt <= ovl_cnt + 1'b1;
				end
				2'b01: ovl_cnt <= ovl_cnt - 1'b1;
				default: ovl_cnt <= ovl_cnt;  // both at once cancel
			endcase
		end
	end

endmodule

// File: fifo_load_fsm.sv
`timescale 1ns/100ps

module fifo_load_fsm (
	input  logic     CLK40,
	input  logic     RST_RESYNC,
	input  logic     l1a_match,
	input  logic     smp_stb,
	input  logic     ovl_pend,
	load_ctrl_if.fsm lc,
	output logic     busy,
	output logic     evt_done
);
	import daq_pkg::*;

	load_state_t state;
	load_state_t state_nxt;

	always_ff @(posedge CLK40) begin
		if (RST_RESYNC)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt  = state;
		lc.cnt_clr = 1'b0;
		evt_done   = 1'b0;
		case (state)
			IDLE: begin
				if (l1a_match) begin
					lc.cnt_clr = 1'b1;  // fresh event
					// strobe in the match cycle already counts
					state_nxt = smp_stb ? LOAD : WAIT_SMP;
				end
			end
			WAIT_SMP: begin
				if (smp_stb)
					state_nxt = LOAD;
			end
			LOAD: begin
				if (lc.grp_last)
					state_nxt = LAST_CHECK;
			end
			LAST_CHECK: begin
				if (lc.smp_last && ovl_pend) begin
					// overlapped match, run one more full event
					evt_done   = 1'b1;
					lc.cnt_clr = 1'b1;
					state_nxt  = WAIT_SMP;
				end else if (lc.smp_last) begin
					state_nxt = IDLE;
				end else begin
					state_nxt = WAIT_SMP;  // more periods to go
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	assign lc.wren = (state == LOAD);
	assign busy    = (state != IDLE);  // match now counts as overlap

endmodule

// File: load_ctrl_if.sv
`timescale 1ns/100ps

interface load_ctrl_if;
	import daq_pkg::*;

	logic             wren;      // write strobe for the channel bank
	logic             cnt_clr;   // clear group and sample counts
	logic [GRP_W-1:0] sel;       // current group bus
	logic             grp_last;  // last slice of a sample period
	logic             smp_last;  // last sample period of the event

	modport fsm (
		output wren,
		output cnt_clr,
		input  grp_last,
		input  smp_last
	);

	modport cnt (
		input  wren,
		input  cnt_clr,
		output sel,
		output grp_last,
		output smp_last
	);

	modport bank (input sel, input wren);

endinterface

// File: daq_pkg.sv
package daq_pkg;

	////////////////////////////////////////////////////////////
	// front-end geometry
	////////////////////////////////////////////////////////////
	localparam int NUM_CH  = 16;  // adc channels
	localparam int SMP_W   = 12;  // bits per adc sample
	localparam int NUM_GRP = 6;   // time-slices per sample period
	localparam int GRP_W   = 3;   // group select width

	// buffer sizes
	localparam int CH_DEPTH   = 256;
	localparam int CH_AW      = $clog2(CH_DEPTH);
	localparam int INFO_DEPTH = 16;
	localparam int INFO_AW    = $clog2(INFO_DEPTH);

	// counter widths
	localparam int L1A_CNT_W  = 24;
	localparam int MTCH_CNT_W = 12;
	localparam int OVL_W      = 4;
	localparam int SMAX_W     = 7;
	localparam logic [OVL_W-1:0] OVL_MAX = '1;  // overlap count saturates here

	localparam int INFO_W = 1 + OVL_W + MTCH_CNT_W + L1A_CNT_W;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_SMP,    // armed, waiting for the sample strobe
		LOAD,        // six group writes
		LAST_CHECK   // decide end of event or next period
	} load_state_t;

	// event-info word, msb first
	typedef struct packed {
		logic                  ovl_flag;
		logic [OVL_W-1:0]      ovl_cnt;
		logic [MTCH_CNT_W-1:0] mtch_cnt;
		logic [L1A_CNT_W-1:0]  l1a_cnt;
	} info_word_t;

endpackage
